//--- hdl/bpu_types_pkg.sv
// Branch prediction type definitions
// Branch kinds stored in the BTB and the states of the
// 2-bit saturating direction counters in the PHT

package bpu_types_pkg;

    // ------------------------------------------------
    // Branch type, as stored per BTB entry
    // ------------------------------------------------
    // PC-relative doubles as the conditional kind and the miss report
    typedef enum logic [1:0] {
        BR_PC_RELATIVE = 2'b00,
        BR_CALL        = 2'b01,
        BR_RETURN      = 2'b10,
        BR_INDIRECT    = 2'b11
    } br_type_t;

    // ------------------------------------------------
    // Direction counter states
    // ------------------------------------------------
    // MSB is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_state_t;

endpackage

//--- hdl/bpu_addr_pkg.sv
// Address field definitions for the branch predictor
// Tag width, sequential fetch step and the tag folding
// function shared by the BTB and the prediction stage

package bpu_addr_pkg;

    // ------------------------------------------------
    // Field widths and fetch geometry
    // ------------------------------------------------
    // Folded tag width
    localparam int TAG_WIDTH = 15;

    // Bytes per fetch access, two 32-bit instructions
    localparam int FETCH_STEP = 8;

    // ------------------------------------------------
    // Tag folding
    // ------------------------------------------------
    // Upper half of the word address XORed onto the lower half
    // Index bits take part too; cheap and good enough for aliasing
    function automatic logic [TAG_WIDTH-1:0] make_tag(
        input logic [31:2] pc
    );
        logic [TAG_WIDTH-1:0] folded;
        folded = pc[31:17] ^ pc[16:2];
        return folded;
    endfunction

endpackage

//--- hdl/sdpram.sv
// Simple dual-port table
// One write port and one read port, read every clock edge.
// A flop per entry tracks validity; reset clears them all.
// Read of an entry being written returns the old contents.

`timescale 1ns/10ps

module sdpram #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rvalid
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // Data array, no reset
    logic [DATA_WIDTH-1:0] mem [DEPTH];
    // Entry valid flags
    logic [DEPTH-1:0]      valid_bits;

    // Write side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[waddr] <= 1'b1;
        end
    end

    // Registered read, old value on a same-index write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= valid_bits[raddr];
        end
    end

endmodule

//--- hdl/btb.sv
// Branch target buffer
// Direct-mapped; each entry is a folded tag, target and type.
// Lookup reads the entry in one cycle, the tag compare follows
// on the registered RAM output. Taken updates write an entry.

`timescale 1ns/10ps

module btb
    import bpu_types_pkg::*;
    import bpu_addr_pkg::*;
#(
    parameter int ADDR_WIDTH = 6,
    parameter int BANK       = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:2] rpc,
    input  logic        upd_valid,
    input  logic        upd_taken,
    input  logic [31:2] wpc,
    input  logic [31:2] bta_i,
    input  br_type_t    br_type_i,
    output logic        hit,
    output logic [31:2] bta_o,
    output br_type_t    br_type_o
);

    // ------------------------------------------------
    // Entry layout: {tag, target, type}
    // ------------------------------------------------
    localparam int ENTRY_WIDTH = TAG_WIDTH + 30 + 2;

    logic [ADDR_WIDTH-1:0]  rd_index;
    logic [ADDR_WIDTH-1:0]  wr_index;
    logic [TAG_WIDTH-1:0]   rd_tag;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [TAG_WIDTH-1:0]   rd_tag_q;
    logic                   we;
    logic [ENTRY_WIDTH-1:0] wr_entry;
    logic [ENTRY_WIDTH-1:0] rd_entry;
    logic                   rd_valid;
    logic [TAG_WIDTH-1:0]   ent_tag;
    logic [31:2]            ent_bta;
    logic [1:0]             ent_type;

    // Index skips BANK low word bits
    assign rd_index = rpc[ADDR_WIDTH+1+BANK : 2+BANK];
    assign wr_index = wpc[ADDR_WIDTH+1+BANK : 2+BANK];
    assign rd_tag   = make_tag(rpc);
    assign wr_tag   = make_tag(wpc);

    // Only taken branches allocate
    assign we       = upd_valid & upd_taken;
    assign wr_entry = {wr_tag, bta_i, br_type_i};

    // Lookup tag lines up with the RAM read
    always_ff @(posedge clk) begin
        rd_tag_q <= rd_tag;
    end

    sdpram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (ENTRY_WIDTH)
    ) u_table (
        .clk    (clk),
        .reset  (reset),
        .we     (we),
        .raddr  (rd_index),
        .waddr  (wr_index),
        .wdata  (wr_entry),
        .rdata  (rd_entry),
        .rvalid (rd_valid)
    );

    // ------------------------------------------------
    // Tag compare on the read data
    // ------------------------------------------------
    assign {ent_tag, ent_bta, ent_type} = rd_entry;

    assign hit       = rd_valid && (ent_tag == rd_tag_q);
    // Target only meaningful on a hit
    assign bta_o     = ent_bta;
    assign br_type_o = hit ? br_type_t'(ent_type) : BR_PC_RELATIVE;

endmodule

//--- hdl/pht.sv
// Pattern history table
// Array of 2-bit saturating counters indexed by PC bits.
// Registered read returns the direction bit; updates move the
// addressed counter one step toward the resolved direction.

`timescale 1ns/10ps

module pht
    import bpu_types_pkg::*;
#(
    parameter int ADDR_WIDTH = 8,
    parameter int BANK       = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:2] rpc,
    input  logic        upd_valid,
    input  logic [31:2] upd_pc,
    input  logic        upd_taken,
    output logic        ctr_taken
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    ctr_state_t            ctr [DEPTH];
    logic [ADDR_WIDTH-1:0] rd_index;
    logic [ADDR_WIDTH-1:0] wr_index;

    assign rd_index = rpc[ADDR_WIDTH+1+BANK : 2+BANK];
    assign wr_index = upd_pc[ADDR_WIDTH+1+BANK : 2+BANK];

    // ------------------------------------------------
    // Saturating step
    // ------------------------------------------------
    function automatic ctr_state_t next_state(
        input ctr_state_t cur,
        input logic       taken
    );
        ctr_state_t nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    // Counter array, all weakly not-taken out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr[i] <= WEAK_NT;
            end
        end else if (upd_valid) begin
            ctr[wr_index] <= next_state(ctr[wr_index], upd_taken);
        end
    end

    // Direction bit, old state on a same-edge update
    always_ff @(posedge clk) begin
        ctr_taken <= ctr[rd_index][1];
    end

endmodule

//--- hdl/pred_select.sv
// Prediction select stage
// Delays the fetch strobe and PC alongside the table read, then
// merges BTB and PHT results into a registered prediction.

`timescale 1ns/10ps

module pred_select
    import bpu_types_pkg::*;
    import bpu_addr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch,
    input  logic [31:2] fetch_pc,
    input  logic        hit,
    input  logic [31:2] bta,
    input  br_type_t    br_type,
    input  logic        ctr_taken,
    output logic        pred_valid,
    output logic [31:2] pred_pc,
    output logic        pred_taken,
    output br_type_t    pred_type,
    output logic        pred_hit
);

    // Sequential step in words
    localparam logic [31:2] SEQ_INC = 30'(FETCH_STEP / 4);

    logic        fetch_q;
    logic [31:2] pc_q;
    logic        taken_c;
    logic [31:2] next_pc_c;

    // ------------------------------------------------
    // Stage 1, in step with the RAM read
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_q <= 1'b0;
        end else begin
            fetch_q <= fetch;
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= fetch_pc;
    end

    // Unconditional kinds always taken, conditional asks the PHT
    assign taken_c   = hit && ((br_type != BR_PC_RELATIVE) || ctr_taken);
    assign next_pc_c = taken_c ? bta : pc_q + SEQ_INC;

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= fetch_q;
            pred_taken <= taken_c;
            pred_hit   <= hit;
        end
    end

    always_ff @(posedge clk) begin
        pred_pc   <= next_pc_c;
        pred_type <= br_type;
    end

endmodule

//--- hdl/bpu_top.sv
// Branch prediction lookup front end
// BTB and PHT are read in parallel on a fetch; the select stage
// registers the prediction two edges after the fetch strobe.
// One update port trains the PHT and fills the BTB.

`timescale 1ns/10ps

module bpu_top
    import bpu_types_pkg::*;
#(
    parameter int BTB_ADDR_WIDTH = 6,
    parameter int PHT_ADDR_WIDTH = 8,
    parameter int BANK           = 1
) (
    input  logic        clk,
    input  logic        reset,
    // Lookup
    input  logic        fetch,
    input  logic [31:2] fetch_pc,
    // Update from branch resolution
    input  logic        upd_valid,
    input  logic [31:2] upd_pc,
    input  logic        upd_taken,
    input  logic [31:2] upd_target,
    input  br_type_t    upd_type,
    // Prediction
    output logic        pred_valid,
    output logic [31:2] pred_pc,
    output logic        pred_taken,
    output br_type_t    pred_type,
    output logic        pred_hit
);

    logic        btb_hit;
    logic [31:2] btb_bta;
    br_type_t    btb_type;
    logic        pht_taken;

    // ------------------------------------------------
    // Tables
    // ------------------------------------------------
    btb #(
        .ADDR_WIDTH (BTB_ADDR_WIDTH),
        .BANK       (BANK)
    ) u_btb (
        .clk       (clk),
        .reset     (reset),
        .rpc       (fetch_pc),
        .upd_valid (upd_valid),
        .upd_taken (upd_taken),
        .wpc       (upd_pc),
        .bta_i     (upd_target),
        .br_type_i (upd_type),
        .hit       (btb_hit),
        .bta_o     (btb_bta),
        .br_type_o (btb_type)
    );

    pht #(
        .ADDR_WIDTH (PHT_ADDR_WIDTH),
        .BANK       (BANK)
    ) u_pht (
        .clk       (clk),
        .reset     (reset),
        .rpc       (fetch_pc),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken),
        .ctr_taken (pht_taken)
    );

    // Final stage
    pred_select u_select (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch),
        .fetch_pc   (fetch_pc),
        .hit        (btb_hit),
        .bta        (btb_bta),
        .br_type    (btb_type),
        .ctr_taken  (pht_taken),
        .pred_valid (pred_valid),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken),
        .pred_type  (pred_type),
        .pred_hit   (pred_hit)
    );

endmodule

//--- sim/bpu_tb.sv
// Branch prediction front end testbench
// Reference model of the BTB and PHT tables, LFSR driven stimulus
// and concurrent assertions on the registered prediction outputs

`timescale 1ns/10ps

module bpu_tb
    import bpu_types_pkg::*;
    import bpu_addr_pkg::*;
();

    localparam int BTB_AW      = 6;
    localparam int PHT_AW      = 8;
    localparam int BANK        = 1;
    localparam int BTB_DEPTH   = 1 << BTB_AW;
    localparam int PHT_DEPTH   = 1 << PHT_AW;
    localparam int RAND_CYCLES = 2000;
    // Roughly twice the whole stimulus
    localparam int MAX_CYCLES  = 5000;

    logic        clk;
    logic        reset;
    logic        fetch;
    logic [31:2] fetch_pc;
    logic        upd_valid;
    logic [31:2] upd_pc;
    logic        upd_taken;
    logic [31:2] upd_target;
    br_type_t    upd_type;
    logic        pred_valid;
    logic [31:2] pred_pc;
    logic        pred_taken;
    br_type_t    pred_type;
    logic        pred_hit;

    // Model tables
    logic                 m_valid  [BTB_DEPTH];
    logic [TAG_WIDTH-1:0] m_tag    [BTB_DEPTH];
    logic [31:2]          m_target [BTB_DEPTH];
    br_type_t             m_type   [BTB_DEPTH];
    ctr_state_t           m_ctr    [PHT_DEPTH];

    // Two expected results in flight
    // Entry 1 is the one at the outputs
    logic        exp_valid [2];
    logic        exp_hit   [2];
    logic        exp_taken [2];
    br_type_t    exp_type  [2];
    logic [31:2] exp_pc    [2];

    logic [31:2] pc_pool [8];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    bpu_top #(
        .BTB_ADDR_WIDTH (BTB_AW),
        .PHT_ADDR_WIDTH (PHT_AW),
        .BANK           (BANK)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch),
        .fetch_pc   (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .upd_type   (upd_type),
        .pred_valid (pred_valid),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken),
        .pred_type  (pred_type),
        .pred_hit   (pred_hit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Address helpers
    // --------------------------------------------------
    function automatic logic [31:2] word_addr(input logic [31:0] a);
        return a[31:2];
    endfunction

    // Field above the skipped bank bits
    function automatic logic [BTB_AW-1:0] btb_index(input logic [31:2] pc);
        return BTB_AW'(pc >> BANK);
    endfunction

    function automatic logic [PHT_AW-1:0] pht_index(input logic [31:2] pc);
        return PHT_AW'(pc >> BANK);
    endfunction

    // PC bit b+15 folded onto PC bit b for b in 2..16
    function automatic logic [TAG_WIDTH-1:0] fold_tag(input logic [31:2] pc);
        logic [TAG_WIDTH-1:0] t;
        for (int b = 2; b <= 16; b++) begin
            t[b-2] = pc[b] ^ pc[b+15];
        end
        return t;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // --------------------------------------------------
    // Stimulus drivers
    // --------------------------------------------------
    task automatic drive_cycle(
        input logic        f,
        input logic [31:2] fpc,
        input logic        uv,
        input logic [31:2] upc,
        input logic        ut,
        input logic [31:2] utgt,
        input br_type_t    utype
    );
        @(posedge clk);
        fetch      <= f;
        fetch_pc   <= fpc;
        upd_valid  <= uv;
        upd_pc     <= upc;
        upd_taken  <= ut;
        upd_target <= utgt;
        upd_type   <= utype;
    endtask

    task automatic lookup(input logic [31:2] pc);
        drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0, BR_PC_RELATIVE);
    endtask

    task automatic train(
        input logic [31:2] pc,
        input logic        taken,
        input logic [31:2] target,
        input br_type_t    kind
    );
        drive_cycle(1'b0, '0, 1'b1, pc, taken, target, kind);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, BR_PC_RELATIVE);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    always @(posedge clk) begin : ref_model
        logic [BTB_AW-1:0] bi;
        logic [PHT_AW-1:0] pi;
        logic              hit_c;
        logic              taken_c;
        if (reset) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                m_ctr[i] = WEAK_NT;
            end
            exp_valid[0] <= 1'b0;
            exp_valid[1] <= 1'b0;
        end else begin
            // Lookup first, so a same-edge update is not seen
            bi = btb_index(fetch_pc);
            pi = pht_index(fetch_pc);
            hit_c = m_valid[bi] && (m_tag[bi] == fold_tag(fetch_pc));
            taken_c = hit_c && ((m_type[bi] != BR_PC_RELATIVE) || m_ctr[pi][1]);
            exp_valid[1] <= exp_valid[0];
            exp_hit[1]   <= exp_hit[0];
            exp_taken[1] <= exp_taken[0];
            exp_type[1]  <= exp_type[0];
            exp_pc[1]    <= exp_pc[0];
            exp_valid[0] <= fetch;
            exp_hit[0]   <= hit_c;
            exp_taken[0] <= taken_c;
            exp_type[0]  <= hit_c ? m_type[bi] : BR_PC_RELATIVE;
            exp_pc[0]    <= taken_c ? m_target[bi] : fetch_pc + 30'(FETCH_STEP >> 2);
            if (upd_valid) begin
                bi = btb_index(upd_pc);
                pi = pht_index(upd_pc);
                if (upd_taken && m_ctr[pi] != STRONG_T) begin
                    m_ctr[pi] = ctr_state_t'(m_ctr[pi] + 2'd1);
                end else if (!upd_taken && m_ctr[pi] != STRONG_NT) begin
                    m_ctr[pi] = ctr_state_t'(m_ctr[pi] - 2'd1);
                end
                // Only taken branches allocate
                if (upd_taken) begin
                    m_valid[bi]  = 1'b1;
                    m_tag[bi]    = fold_tag(upd_pc);
                    m_target[bi] = upd_target;
                    m_type[bi]   = upd_type;
                end
            end
        end
    end

    // --------------------------------------------------
    // Output checks
    // --------------------------------------------------
    valid_chk: assert property (@(posedge clk) disable iff (reset)
        pred_valid == exp_valid[1])
        else report_mismatch("pred_valid not two edges after the fetch strobe");
    hit_chk: assert property (@(posedge clk) disable iff (reset)
        !exp_valid[1] || pred_hit == exp_hit[1])
        else report_mismatch("pred_hit differs from the model BTB");
    taken_chk: assert property (@(posedge clk) disable iff (reset)
        !exp_valid[1] || pred_taken == exp_taken[1])
        else report_mismatch("pred_taken differs from the model");
    type_chk: assert property (@(posedge clk) disable iff (reset)
        !exp_valid[1] || pred_type == exp_type[1])
        else report_mismatch("pred_type differs from the model");
    pc_chk: assert property (@(posedge clk) disable iff (reset)
        !exp_valid[1] || pred_pc == exp_pc[1])
        else report_mismatch($sformatf("pred_pc %h, expected %h", pred_pc, exp_pc[1]));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] r;
        logic        f;
        logic [31:2] fpc;
        logic [31:2] upc;
        logic [31:2] tgt;
        lfsr_state = 32'd86127;
        fetch      = 1'b0;
        fetch_pc   = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
        upd_type   = BR_PC_RELATIVE;
        reset      = 1'b1;
        // Entries 0, 1 and 3 share both table indices
        // Entries 1 and 3 also fold to the same tag
        // Entry 2 shares only the BTB index with entry 0
        // Entries 4 and 5 differ only in the tag
        pc_pool[0] = word_addr(32'h0000_1000);
        pc_pool[1] = word_addr(32'h0000_1004);
        pc_pool[2] = word_addr(32'h0000_1200);
        pc_pool[3] = word_addr(32'h0002_1000);
        pc_pool[4] = word_addr(32'h0000_2058);
        pc_pool[5] = word_addr(32'h8000_2058);
        pc_pool[6] = word_addr(32'h0000_0ff8);
        pc_pool[7] = word_addr(32'h1234_5678);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Misses on the empty tables with gaps in the strobe
        for (int i = 0; i < 8; i++) begin
            lookup(pc_pool[i]);
            if (i % 2 == 1) begin
                idle_cycle();
            end
        end

        // Unconditional kinds
        train(pc_pool[4], 1'b1, word_addr(32'h0000_4000), BR_CALL);
        lookup(pc_pool[4]);
        train(pc_pool[6], 1'b1, word_addr(32'h0000_5000), BR_RETURN);
        lookup(pc_pool[6]);
        train(pc_pool[7], 1'b1, word_addr(32'h0000_6000), BR_INDIRECT);
        lookup(pc_pool[7]);
        lookup(pc_pool[5]);

        // Conditional branch walks the counter up then down
        tgt = word_addr(32'h0000_0800);
        repeat (3) begin
            train(pc_pool[0], 1'b1, tgt, BR_PC_RELATIVE);
            lookup(pc_pool[0]);
        end
        repeat (4) begin
            train(pc_pool[0], 1'b0, word_addr(32'hffff_0000), BR_PC_RELATIVE);
            lookup(pc_pool[0]);
        end
        train(pc_pool[0], 1'b1, tgt, BR_PC_RELATIVE);
        lookup(pc_pool[0]);

        // PCs on one BTB index with different tags evict each other
        train(pc_pool[2], 1'b1, word_addr(32'h0000_7000), BR_INDIRECT);
        lookup(pc_pool[2]);
        lookup(pc_pool[0]);
        train(pc_pool[0], 1'b1, word_addr(32'h0000_7800), BR_CALL);
        lookup(pc_pool[0]);
        lookup(pc_pool[2]);

        // Update and lookup of one entry in the same cycle
        drive_cycle(1'b1, pc_pool[6], 1'b1, pc_pool[6], 1'b1,
                    word_addr(32'h0000_9000), BR_CALL);
        lookup(pc_pool[6]);

        // Random traffic with back-to-back lookups
        repeat (RAND_CYCLES) begin
            r = draw_bits(2);
            f = (r[1:0] != 2'b00);
            r = draw_bits(3);
            fpc = pc_pool[r[2:0]];
            r = draw_bits(3);
            upc = pc_pool[r[2:0]];
            r = draw_bits(2);
            if (r[1:0] == 2'b00) begin
                upc = fpc;
            end
            r = draw_bits(30);
            tgt = r[29:0];
            r = draw_bits(4);
            drive_cycle(f, fpc, r[0], upc, r[1], tgt, br_type_t'(r[3:2]));
        end

        // Drain the pipeline
        repeat (4) idle_cycle();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- bpu.f
hdl/bpu_types_pkg.sv
hdl/bpu_addr_pkg.sv
hdl/sdpram.sv
hdl/btb.sv
hdl/pht.sv
hdl/pred_select.sv
hdl/bpu_top.sv
sim/bpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the BPU testbench with Verilator, run it and check the result
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module bpu_tb -f bpu.f -o bpu_sim || exit 1
out=$(./obj_dir/bpu_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "All tests passed" \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
